// ==== src/qe_cfg.svh ====
// widths, register map and synchroniser depth for the quadrature encoder channel
// include wherever these values are needed; the types live in qe_pkg

`ifndef QE_CFG_SVH
`define QE_CFG_SVH

//////////////////////////////////////////////////
// bus widths

`define QE_DATA_W           32
`define QE_ADDR_W           8

//////////////////////////////////////////////////
// register map, offsets within one channel window

`define QE_NUM_REGS         6

`define QE_REG_COUNT        0
`define QE_REG_TURNS        1
`define QE_REG_PHASE_TIME   2
`define QE_REG_CPR          3
`define QE_REG_CONFIG       4
`define QE_REG_STATUS       5

//////////////////////////////////////////////////
// line conditioning

// flop stages on the async encoder inputs
`define QE_SYNC_STAGES      2

`endif

// ==== src/qe_pkg.sv ====
// shared types for the quadrature encoder channel
// referenced by scoped name from the RTL and the testbench

`include "qe_cfg.svh"

package qe_pkg;

    typedef logic [`QE_DATA_W-1:0] data_t;
    typedef logic [`QE_ADDR_W-1:0] addr_t;

    // register port request, wr and rd are single-cycle strobes
    typedef struct packed {
        logic  wr;
        logic  rd;
        addr_t addr;
        data_t wdata;
    } reg_req_t;

    typedef struct packed {
        logic a;
        logic b;
        logic i;
    } qe_lines_t;

    typedef enum logic {
        QE_CCW = 1'b0,
        QE_CW  = 1'b1
    } qe_dir_e;

    typedef enum logic {
        QE_EXTERNAL = 1'b0,
        QE_INTERNAL = 1'b1
    } qe_source_e;

    // config register, source sits in bit 0
    typedef struct packed {
        logic [`QE_DATA_W-5:0] reserved;
        logic                  flip_ab;
        qe_dir_e               sim_dir;
        logic                  sim_enable;
        qe_source_e            source;
    } qe_config_t;

    // decoder output, dir holds the last step direction
    typedef struct packed {
        logic    step;
        qe_dir_e dir;
        logic    index;
    } qe_step_t;

endpackage

// ==== src/qe_reg_decode.sv ====
// register decoder for one encoder channel
// matches accesses against the channel window and holds the writable registers

`include "qe_cfg.svh"

module qe_reg_decode #(
    parameter int qe_unit = 0
) (
    input  logic                 clk,
    input  logic                 reset,
    input  qe_pkg::reg_req_t     req,
    output qe_pkg::qe_config_t   cfg,
    output qe_pkg::data_t        phase_time,
    output qe_pkg::data_t        cpr,
    output qe_pkg::data_t        count_wdata,
    output logic                 count_load,
    output logic                 rd_hit,
    output qe_pkg::addr_t        rd_sel
);

    // first address of this channel
    localparam int base = qe_unit * `QE_NUM_REGS;

    logic          in_window;
    logic          wr_hit;
    qe_pkg::addr_t offset;

    //////////////////////////////////////////////////
    // address decode

    assign in_window = (int'(req.addr) >= base) &&
                       (int'(req.addr) < base + `QE_NUM_REGS);

    assign offset = req.addr - qe_pkg::addr_t'(base);
    assign wr_hit = req.wr && in_window;

    // the count register itself lives in the counters
    assign count_load  = wr_hit && (offset == qe_pkg::addr_t'(`QE_REG_COUNT));
    assign count_wdata = req.wdata;

    // read select, sampled into rd_data on the same edge by the counters
    assign rd_hit = req.rd && in_window;
    assign rd_sel = offset;

    //////////////////////////////////////////////////
    // writable registers

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            cfg        <= '0;
            phase_time <= '0;
            cpr        <= '0;
        end else if (wr_hit) begin
            case (offset)
                qe_pkg::addr_t'(`QE_REG_PHASE_TIME): begin
                    phase_time <= req.wdata;
                end
                qe_pkg::addr_t'(`QE_REG_CPR): begin
                    cpr <= req.wdata;
                end
                qe_pkg::addr_t'(`QE_REG_CONFIG): begin
                    cfg <= qe_pkg::qe_config_t'(req.wdata);
                end
                // turns and status are read only
                default: begin
                end
            endcase
        end
    end

endmodule

// ==== src/qe_sim_gen.sv ====
// encoder simulator, produces A, B and I from a phase timer and a pulse counter
// one phase step every phase_time+1 cycles while enabled

module qe_sim_gen (
    input  logic              clk,
    input  logic              reset,
    input  logic              sim_enable,
    input  qe_pkg::qe_dir_e   sim_dir,
    input  qe_pkg::data_t     phase_time,
    input  qe_pkg::data_t     cpr,
    output qe_pkg::qe_lines_t sim_lines
);

    logic [1:0]    phase_q;
    qe_pkg::data_t timer_q;
    qe_pkg::data_t pulse_q;
    qe_pkg::data_t pulse_next;
    logic          index_q;
    logic          tick;

    assign tick       = sim_enable && (timer_q == '0);
    assign pulse_next = pulse_q + 1'b1;

    //////////////////////////////////////////////////
    // timer, phase and pulse counters

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            phase_q <= 2'd0;
            timer_q <= '0;
            pulse_q <= '0;
            index_q <= 1'b0;
        end else if (!sim_enable) begin
            // idle, phase and index hold
            timer_q <= '0;
        end else if (tick) begin
            timer_q <= phase_time;
            if (sim_dir == qe_pkg::QE_CW) begin
                phase_q <= phase_q + 2'd1;
            end else begin
                phase_q <= phase_q - 2'd1;
            end
            // index marks the step that completes a revolution
            if (pulse_next == cpr) begin
                pulse_q <= '0;
                index_q <= 1'b1;
            end else begin
                pulse_q <= pulse_next;
                index_q <= 1'b0;
            end
        end else begin
            timer_q <= timer_q - 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // phase to line mapping, AB = 00 10 11 01 as phase rises

    always_comb begin
        sim_lines.i = index_q;
        case (phase_q)
            2'd0: begin
                sim_lines.a = 1'b0;
                sim_lines.b = 1'b0;
            end
            2'd1: begin
                sim_lines.a = 1'b1;
                sim_lines.b = 1'b0;
            end
            2'd2: begin
                sim_lines.a = 1'b1;
                sim_lines.b = 1'b1;
            end
            default: begin
                sim_lines.a = 1'b0;
                sim_lines.b = 1'b1;
            end
        endcase
    end

endmodule

// ==== src/qe_line_cond.sv ====
// line conditioning for the encoder inputs
// synchronises the pins, picks pins or simulator, then optionally swaps A and B

`include "qe_cfg.svh"

module qe_line_cond (
    input  logic               clk,
    input  logic               reset,
    input  logic               ext_a,
    input  logic               ext_b,
    input  logic               ext_i,
    input  qe_pkg::qe_lines_t  sim_lines,
    input  qe_pkg::qe_source_e source,
    input  logic               flip_ab,
    output qe_pkg::qe_lines_t  lines
);

    qe_pkg::qe_lines_t sync_q [`QE_SYNC_STAGES];
    qe_pkg::qe_lines_t src_lines;

    //////////////////////////////////////////////////
    // synchroniser, all three pins share one chain

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int n = 0; n < `QE_SYNC_STAGES; n++) begin
                sync_q[n] <= '0;
            end
        end else begin
            sync_q[0].a <= ext_a;
            sync_q[0].b <= ext_b;
            sync_q[0].i <= ext_i;
            for (int n = 1; n < `QE_SYNC_STAGES; n++) begin
                sync_q[n] <= sync_q[n-1];
            end
        end
    end

    // simulator lines are already synchronous and bypass the chain
    always_comb begin
        if (source == qe_pkg::QE_INTERNAL) begin
            src_lines = sim_lines;
        end else begin
            src_lines = sync_q[`QE_SYNC_STAGES-1];
        end
    end

    // swap reverses the counting direction
    always_comb begin
        lines.i = src_lines.i;
        if (flip_ab) begin
            lines.a = src_lines.b;
            lines.b = src_lines.a;
        end else begin
            lines.a = src_lines.a;
            lines.b = src_lines.b;
        end
    end

endmodule

// ==== src/qe_step_decode.sv ====
// quadrature step decoder
// compares the lines with their previous value and emits registered step and index strobes

module qe_step_decode (
    input  logic              clk,
    input  logic              reset,
    input  qe_pkg::qe_lines_t lines,
    output qe_pkg::qe_step_t  step
);

    qe_pkg::qe_lines_t prev_q;
    logic              a_chg;
    logic              b_chg;
    logic              one_chg;
    logic              i_rise;
    logic [1:0]        diff;
    qe_pkg::qe_dir_e   cur_dir;

    // position of AB in the sequence 00 10 11 01
    function automatic logic [1:0] phase_of(input qe_pkg::qe_lines_t l);
        return {l.b, l.a ^ l.b};
    endfunction

    //////////////////////////////////////////////////
    // change detection

    assign a_chg   = lines.a ^ prev_q.a;
    assign b_chg   = lines.b ^ prev_q.b;
    // both lines moving together is an illegal jump
    assign one_chg = a_chg ^ b_chg;
    assign i_rise  = lines.i & ~prev_q.i;

    assign diff = phase_of(lines) - phase_of(prev_q);

    always_comb begin
        if (diff == 2'd1) begin
            cur_dir = qe_pkg::QE_CW;
        end else begin
            cur_dir = qe_pkg::QE_CCW;
        end
    end

    //////////////////////////////////////////////////
    // registered outputs

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            prev_q <= '0;
            step   <= '0;
        end else begin
            prev_q     <= lines;
            step.step  <= one_chg;
            step.index <= i_rise;
            // dir is kept between steps so an index pulse
            // carries the direction of the latest step
            if (one_chg) begin
                step.dir <= cur_dir;
            end
        end
    end

endmodule

// ==== src/qe_counters.sv ====
// position and turns counters with the register readback
// rd_data is captured on the edge that samples the read strobe

`include "qe_cfg.svh"

module qe_counters (
    input  logic               clk,
    input  logic               reset,
    input  qe_pkg::qe_step_t   step,
    input  logic               count_load,
    input  qe_pkg::data_t      count_wdata,
    input  logic               rd_hit,
    input  qe_pkg::addr_t      rd_sel,
    input  qe_pkg::qe_config_t cfg,
    input  qe_pkg::data_t      phase_time,
    input  qe_pkg::data_t      cpr,
    input  qe_pkg::qe_lines_t  lines,
    output qe_pkg::data_t      rd_data,
    output logic               rd_valid
);

    qe_pkg::data_t count_q;
    qe_pkg::data_t turns_q;
    qe_pkg::data_t rd_word;

    //////////////////////////////////////////////////
    // position and turns, two's complement

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            count_q <= '0;
            turns_q <= '0;
        end else begin
            // a step wins over a preload on the same edge
            if (step.step) begin
                count_q <= (step.dir == qe_pkg::QE_CW) ? count_q + 1'b1 : count_q - 1'b1;
            end else if (count_load) begin
                count_q <= count_wdata;
            end
            if (step.index) begin
                turns_q <= (step.dir == qe_pkg::QE_CW) ? turns_q + 1'b1 : turns_q - 1'b1;
            end
        end
    end

    // readback mux
    always_comb begin
        case (rd_sel)
            qe_pkg::addr_t'(`QE_REG_COUNT):      rd_word = count_q;
            qe_pkg::addr_t'(`QE_REG_TURNS):      rd_word = turns_q;
            qe_pkg::addr_t'(`QE_REG_PHASE_TIME): rd_word = phase_time;
            qe_pkg::addr_t'(`QE_REG_CPR):        rd_word = cpr;
            qe_pkg::addr_t'(`QE_REG_CONFIG):     rd_word = cfg;
            qe_pkg::addr_t'(`QE_REG_STATUS):     rd_word = {{(`QE_DATA_W-3){1'b0}}, lines};
            default:                             rd_word = '0;
        endcase
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            rd_data  <= '0;
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= rd_hit;
            if (rd_hit) begin
                rd_data <= rd_word;
            end
        end
    end

endmodule

// ==== src/qe_channel.sv ====
// one quadrature encoder channel behind a strobe register port
// qe_unit selects the register window of this channel

module qe_channel #(
    parameter int qe_unit = 0
) (
    input  logic              clk,
    input  logic              reset,
    input  qe_pkg::reg_req_t  req,
    input  logic              ext_a,
    input  logic              ext_b,
    input  logic              ext_i,
    output qe_pkg::data_t     rd_data,
    output logic              rd_valid,
    output qe_pkg::qe_lines_t status
);

    qe_pkg::qe_config_t cfg;
    qe_pkg::data_t      phase_time;
    qe_pkg::data_t      cpr;
    qe_pkg::data_t      count_wdata;
    logic               count_load;
    logic               rd_hit;
    qe_pkg::addr_t      rd_sel;
    qe_pkg::qe_lines_t  sim_lines;
    qe_pkg::qe_lines_t  lines;
    qe_pkg::qe_step_t   step;

    //////////////////////////////////////////////////
    // decode

    qe_reg_decode #(
        .qe_unit (qe_unit)
    ) u_reg_decode (
        .clk         (clk),
        .reset       (reset),
        .req         (req),
        .cfg         (cfg),
        .phase_time  (phase_time),
        .cpr         (cpr),
        .count_wdata (count_wdata),
        .count_load  (count_load),
        .rd_hit      (rd_hit),
        .rd_sel      (rd_sel)
    );

    //////////////////////////////////////////////////
    // execute

    qe_sim_gen u_sim_gen (
        .clk        (clk),
        .reset      (reset),
        .sim_enable (cfg.sim_enable),
        .sim_dir    (cfg.sim_dir),
        .phase_time (phase_time),
        .cpr        (cpr),
        .sim_lines  (sim_lines)
    );

    qe_line_cond u_line_cond (
        .clk       (clk),
        .reset     (reset),
        .ext_a     (ext_a),
        .ext_b     (ext_b),
        .ext_i     (ext_i),
        .sim_lines (sim_lines),
        .source    (cfg.source),
        .flip_ab   (cfg.flip_ab),
        .lines     (lines)
    );

    qe_step_decode u_step_decode (
        .clk   (clk),
        .reset (reset),
        .lines (lines),
        .step  (step)
    );

    //////////////////////////////////////////////////
    // result

    qe_counters u_counters (
        .clk         (clk),
        .reset       (reset),
        .step        (step),
        .count_load  (count_load),
        .count_wdata (count_wdata),
        .rd_hit      (rd_hit),
        .rd_sel      (rd_sel),
        .cfg         (cfg),
        .phase_time  (phase_time),
        .cpr         (cpr),
        .lines       (lines),
        .rd_data     (rd_data),
        .rd_valid    (rd_valid)
    );

    assign status = lines;

endmodule

// ==== test/tb_qe_channel.sv ====
// testbench for one quadrature encoder channel at unit 1
// steps the external lines and the simulator, checks reads against a reference model

`include "qe_cfg.svh"

module tb_qe_channel;

    localparam int unit          = 1;
    // external steps, preload and index steps, replayed steps and simulator time
    localparam int planned_steps = 200 + 60 + 40 + 200 + 120;
    localparam int limit_cycles  = planned_steps * 40 + 2000;

    localparam logic [1:0] kind_data    = 2'd0;
    localparam logic [1:0] kind_lines   = 2'd1;
    localparam logic [1:0] kind_capture = 2'd2;

    typedef struct packed {
        qe_pkg::data_t   pos;
        qe_pkg::data_t   turns;
        qe_pkg::qe_dir_e dir;
    } model_t;

    typedef struct packed {
        logic [1:0]    kind;
        qe_pkg::data_t value;
    } expect_t;

    logic              clk;
    logic              reset;
    qe_pkg::reg_req_t  req;
    logic              ext_a;
    logic              ext_b;
    logic              ext_i;
    qe_pkg::data_t     rd_data;
    logic              rd_valid;
    qe_pkg::qe_lines_t status;

    int            errors;
    logic [15:0]   lfsr;
    model_t        model;
    logic          cur_a;
    logic          cur_b;
    logic          flip_now;
    expect_t       exp_q[$];
    qe_pkg::data_t cap_q[$];
    logic          dir_q[$];

    qe_channel #(
        .qe_unit (unit)
    ) dut0 (
        .clk      (clk),
        .reset    (reset),
        .req      (req),
        .ext_a    (ext_a),
        .ext_b    (ext_b),
        .ext_i    (ext_i),
        .rd_data  (rd_data),
        .rd_valid (rd_valid),
        .status   (status)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    //////////////////////////////////////////////////
    // helpers and reference model

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output qe_pkg::data_t v);
        v = '0;
        for (int k = 0; k < n; k++) begin
            v = {v[`QE_DATA_W-2:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    function automatic qe_pkg::addr_t win(input int offset);
        return qe_pkg::addr_t'(unit * `QE_NUM_REGS + offset);
    endfunction

    // forward order of AB is 00 10 11 01
    function automatic logic [1:0] seq_index(input logic a, input logic b);
        case ({a, b})
            2'b00:   return 2'd0;
            2'b10:   return 2'd1;
            2'b11:   return 2'd2;
            default: return 2'd3;
        endcase
    endfunction

    function automatic logic [1:0] seq_lines(input logic [1:0] idx);
        case (idx)
            2'd0:    return 2'b00;
            2'd1:    return 2'b10;
            2'd2:    return 2'b11;
            default: return 2'b01;
        endcase
    endfunction

    function automatic model_t model_step(input model_t m, input logic old_a, input logic old_b,
                                          input logic new_a, input logic new_b,
                                          input logic i_rise, input logic flip_ab);
        model_t r;
        logic   oa;
        logic   ob;
        logic   na;
        logic   nb;
        r  = m;
        oa = flip_ab ? old_b : old_a;
        ob = flip_ab ? old_a : old_b;
        na = flip_ab ? new_b : new_a;
        nb = flip_ab ? new_a : new_b;
        // a step needs exactly one of A and B to move
        if ((oa != na) != (ob != nb)) begin
            if (seq_index(na, nb) == seq_index(oa, ob) + 2'd1) begin
                r.pos = m.pos + 1;
                r.dir = qe_pkg::QE_CW;
            end else begin
                r.pos = m.pos - 1;
                r.dir = qe_pkg::QE_CCW;
            end
        end
        // index follows the last step before it
        if (i_rise) begin
            r.turns = (m.dir == qe_pkg::QE_CW) ? m.turns + 1 : m.turns - 1;
        end
        return r;
    endfunction

    task automatic check_data(input string name, input qe_pkg::data_t got,
                              input qe_pkg::data_t exp);
        if (got !== exp) begin
            errors++;
            $display("ERR %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_lines(input string name, input qe_pkg::qe_lines_t got,
                               input qe_pkg::qe_lines_t exp);
        if (got !== exp) begin
            errors++;
            $display("ERR %s got %h expected %h", name, got, exp);
        end
    endtask

    //////////////////////////////////////////////////
    // register port and line drivers

    task automatic issue(input logic wr, input logic rd, input qe_pkg::addr_t a,
                         input qe_pkg::data_t d);
        qe_pkg::reg_req_t r;
        r.wr    = wr;
        r.rd    = rd;
        r.addr  = a;
        r.wdata = d;
        @(posedge clk);
        req <= r;
        @(posedge clk);
        req <= '0;
    endtask

    task automatic write_reg(input qe_pkg::addr_t a, input qe_pkg::data_t d);
        issue(1'b1, 1'b0, a, d);
    endtask

    task automatic read_reg(input qe_pkg::addr_t a, input logic [1:0] kind,
                            input qe_pkg::data_t exp);
        expect_t e;
        e.kind  = kind;
        e.value = exp;
        exp_q.push_back(e);
        issue(1'b0, 1'b1, a, '0);
    endtask

    // value is not known ahead, so the compare process hands it back
    task automatic read_capture(input qe_pkg::addr_t a, output qe_pkg::data_t v);
        read_reg(a, kind_capture, '0);
        while (cap_q.size() == 0) begin
            @(posedge clk);
        end
        v = cap_q.pop_front();
    endtask

    task automatic drive_step(input logic cw);
        logic [1:0] idx;
        logic       na;
        logic       nb;
        idx = seq_index(cur_a, cur_b);
        idx = cw ? idx + 2'd1 : idx - 2'd1;
        {na, nb} = seq_lines(idx);
        @(posedge clk);
        ext_a <= na;
        ext_b <= nb;
        model = model_step(model, cur_a, cur_b, na, nb, 1'b0, flip_now);
        cur_a = na;
        cur_b = nb;
        repeat (7) @(posedge clk);
    endtask

    task automatic pulse_index();
        @(posedge clk);
        ext_i <= 1'b1;
        model = model_step(model, cur_a, cur_b, cur_a, cur_b, 1'b1, flip_now);
        repeat (6) @(posedge clk);
        ext_i <= 1'b0;
        repeat (6) @(posedge clk);
    endtask

    //////////////////////////////////////////////////
    // compare process, one expectation per rd_valid

    initial begin : compare
        expect_t e;
        forever begin
            @(negedge clk);
            if (rd_valid) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("rd_valid came without a read in this channel window");
                end else begin
                    e = exp_q.pop_front();
                    case (e.kind)
                        kind_data:  check_data("rd_data", rd_data, e.value);
                        kind_lines: check_lines("status", qe_pkg::qe_lines_t'(rd_data[2:0]),
                                                qe_pkg::qe_lines_t'(e.value[2:0]));
                        default:    cap_q.push_back(rd_data);
                    endcase
                end
            end
        end
    end

    initial begin : watchdog
        repeat (limit_cycles) @(posedge clk);
        $display("timeout, the tests did not finish within %0d cycles", limit_cycles);
        $display("errors: %0d", errors);
        $display("sim failed");
        $finish;
    end

    //////////////////////////////////////////////////
    // stimulus

    initial begin : stimulus
        qe_pkg::data_t     ph_val;
        qe_pkg::data_t     cpr_val;
        qe_pkg::data_t     cfg_val;
        qe_pkg::data_t     v;
        qe_pkg::data_t     net2;
        qe_pkg::data_t     base;
        qe_pkg::data_t     c1;
        qe_pkg::data_t     c2;
        qe_pkg::data_t     cnt;
        qe_pkg::data_t     trn;
        qe_pkg::qe_lines_t exp_l;
        reset    = 1'b0;
        req      = '0;
        ext_a    = 1'b0;
        ext_b    = 1'b0;
        ext_i    = 1'b0;
        errors   = 0;
        lfsr     = 16'd48;
        model    = '0;
        cur_a    = 1'b0;
        cur_b    = 1'b0;
        flip_now = 1'b0;
        repeat (10) @(posedge clk);
        reset <= 1'b1;
        repeat (2) @(posedge clk);

        // 1: register readback, keep source external and the simulator off
        take_bits(32, ph_val);
        take_bits(32, cpr_val);
        take_bits(32, cfg_val);
        cfg_val = cfg_val & ~32'h0000_000B;
        write_reg(win(`QE_REG_PHASE_TIME), ph_val);
        write_reg(win(`QE_REG_CPR), cpr_val);
        write_reg(win(`QE_REG_CONFIG), cfg_val);
        write_reg(qe_pkg::addr_t'(`QE_REG_PHASE_TIME), ~ph_val);
        read_reg(win(`QE_REG_PHASE_TIME), kind_data, ph_val);
        read_reg(win(`QE_REG_CPR), kind_data, cpr_val);
        read_reg(win(`QE_REG_CONFIG), kind_data, cfg_val);
        issue(1'b0, 1'b1, qe_pkg::addr_t'(`QE_REG_CONFIG), '0);
        issue(1'b0, 1'b1, win(`QE_NUM_REGS), '0);
        repeat (4) @(posedge clk);

        // 2: random external stepping
        for (int k = 0; k < 200; k++) begin
            take_bits(1, v);
            dir_q.push_back(v[0]);
            drive_step(v[0]);
        end
        net2 = model.pos;
        read_reg(win(`QE_REG_COUNT), kind_data, model.pos);
        exp_l.a = cur_a;
        exp_l.b = cur_b;
        exp_l.i = 1'b0;
        @(negedge clk);
        check_lines("status", status, exp_l);
        read_reg(win(`QE_REG_STATUS), kind_lines, qe_pkg::data_t'(exp_l));

        // 3: preload then more steps
        take_bits(32, v);
        write_reg(win(`QE_REG_COUNT), v);
        model.pos = v;
        for (int k = 0; k < 30; k++) begin
            take_bits(1, v);
            drive_step(v[0]);
        end
        read_reg(win(`QE_REG_COUNT), kind_data, model.pos);

        // 4: index pulses after runs in both directions
        for (int k = 0; k < 4; k++) begin
            repeat (3) drive_step(1'b1);
            pulse_index();
            read_reg(win(`QE_REG_TURNS), kind_data, model.turns);
            repeat (2) drive_step(1'b0);
            pulse_index();
        end
        read_reg(win(`QE_REG_TURNS), kind_data, model.turns);
        read_reg(win(`QE_REG_COUNT), kind_data, model.pos);

        // 5: swapped lines, same direction sequence as check 2
        write_reg(win(`QE_REG_CONFIG), 32'h0000_0008);
        flip_now = 1'b1;
        repeat (6) @(posedge clk);
        write_reg(win(`QE_REG_COUNT), '0);
        model.pos = '0;
        foreach (dir_q[k]) begin
            drive_step(dir_q[k]);
        end
        read_capture(win(`QE_REG_COUNT), cnt);
        check_data("count", cnt, -net2);
        check_data("count", cnt, model.pos);

        // 6: internal simulator, CW with 4 counts per revolution
        write_reg(win(`QE_REG_CONFIG), 32'h0000_0001);
        write_reg(win(`QE_REG_CPR), 32'd4);
        write_reg(win(`QE_REG_PHASE_TIME), 32'd3);
        repeat (8) @(posedge clk);
        write_reg(win(`QE_REG_COUNT), '0);
        read_capture(win(`QE_REG_TURNS), base);
        write_reg(win(`QE_REG_CONFIG), 32'h0000_0007);
        repeat (100) @(posedge clk);
        read_capture(win(`QE_REG_COUNT), c1);
        repeat (40) @(posedge clk);
        read_capture(win(`QE_REG_COUNT), c2);
        if ($signed(c2) < $signed(c1)) begin
            errors++;
            $display("ERR count decreased from %h to %h", c1, c2);
        end
        repeat (100) @(posedge clk);
        write_reg(win(`QE_REG_CONFIG), 32'h0000_0001);
        repeat (8) @(posedge clk);
        read_capture(win(`QE_REG_COUNT), cnt);
        read_capture(win(`QE_REG_TURNS), trn);
        if (cnt == '0) begin
            errors++;
            $display("the simulator produced no steps");
        end
        check_data("turns", trn - base, qe_pkg::data_t'($signed(cnt) >>> 2));

        repeat (6) @(posedge clk);
        if (exp_q.size() != 0) begin
            errors++;
            $display("%0d reads never returned rd_valid", exp_q.size());
        end
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
+incdir+src
src/qe_pkg.sv
src/qe_reg_decode.sv
src/qe_sim_gen.sv
src/qe_line_cond.sv
src/qe_step_decode.sv
src/qe_counters.sv
src/qe_channel.sv
test/tb_qe_channel.sv
